// File: bench/keypad_model.sv
`timescale 1ns/1ps

module keypad_model (
    input  logic [3:0]  col_out,
    input  logic        active,
    input  logic [15:0] keys,       // Bit row * 4 + column.
    input  int          hold,       // Visits of its column that a key stays down.
    output logic [3:0]  row_in,
    output logic        done
);

    int         visits [4] = '{default: 0};    // Column visits since time zero.
    int         base   [4] = '{default: 0};    // Visit count when the press began.
    logic [3:0] col_prev = 4'hF;

    // A visit starts when the column line falls.
    always @(col_out) begin
        for (int c = 0; c < 4; c++) begin
            if (col_prev[c] && !col_out[c]) begin
                visits[c] = visits[c] + 1;
            end
        end
        col_prev = col_out;
    end

    always @(posedge active) begin
        for (int c = 0; c < 4; c++) begin
            base[c] = visits[c];
        end
    end

    // ==============================
    // Row drive and done
    // ==============================
    always_comb begin
        int n;
        row_in = 4'hF;
        done   = active;
        for (int c = 0; c < 4; c++) begin
            n = visits[c] - base[c];
            if (n < hold + 2) begin
                done = 1'b0;        // Two released scans follow the hold.
            end
            for (int r = 0; r < 4; r++) begin
                if (active && keys[r*4+c] && !col_out[c] && n >= 1 && n <= hold) begin
                    row_in[r] = 1'b0;
                end
            end
        end
    end

endmodule

// File: bench/tb_keypad_ctrl.sv
`timescale 1ns/1ps

module tb_keypad_ctrl
    import keypad_pkg::*;
();

    localparam int COLUMN_CYCLES = 16;
    localparam int SETTLE_CYCLES = 4;
    localparam int FIFO_DEPTH    = 8;
    localparam int SCAN_CYCLES   = 4 * COLUMN_CYCLES;
    localparam int AXI_OVERHEAD  = 160 * 8;    // Transactions times cycles each.

    logic        clk;
    logic        rst_n;
    logic [3:0]  row_in;
    logic [3:0]  col_out;
    logic [3:0]  s_awaddr;
    logic        s_awvalid;
    logic        s_awready;
    logic [31:0] s_wdata;
    logic [3:0]  s_wstrb;
    logic        s_wvalid;
    logic        s_wready;
    logic [1:0]  s_bresp;
    logic        s_bvalid;
    logic        s_bready;
    logic [3:0]  s_araddr;
    logic        s_arvalid;
    logic        s_arready;
    logic [31:0] s_rdata;
    logic [1:0]  s_rresp;
    logic        s_rvalid;
    logic        s_rready;
    logic        irq;

    logic [15:0] kp_keys;
    int          kp_hold;
    logic        kp_active;
    logic        kp_done;

    logic [15:0] t_keys [$];    // Stimulus table.
    int          t_hold [$];
    int          t_exp  [$];    // Expected key index, -1 for no event.

    logic [31:0] rng    = 32'h3710_15a3;
    int          cycles = 0;
    int          limit  = 0;

    keypad_ctrl_top #(
        .COLUMN_CYCLES (COLUMN_CYCLES),
        .SETTLE_CYCLES (SETTLE_CYCLES),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) u_dut (
        .clk (clk), .rst_n (rst_n), .row_in (row_in), .col_out (col_out),
        .s_awaddr (s_awaddr), .s_awvalid (s_awvalid), .s_awready (s_awready),
        .s_wdata (s_wdata), .s_wstrb (s_wstrb), .s_wvalid (s_wvalid), .s_wready (s_wready),
        .s_bresp (s_bresp), .s_bvalid (s_bvalid), .s_bready (s_bready),
        .s_araddr (s_araddr), .s_arvalid (s_arvalid), .s_arready (s_arready),
        .s_rdata (s_rdata), .s_rresp (s_rresp), .s_rvalid (s_rvalid), .s_rready (s_rready),
        .irq (irq)
    );

    keypad_model u_model (
        .col_out (col_out), .active (kp_active), .keys (kp_keys), .hold (kp_hold),
        .row_in (row_in), .done (kp_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            abort_run($sformatf("Timeout: run did not finish within %0d cycles", limit));
        end
    end

    // ==============================
    // Expected values and helpers
    // ==============================
    function automatic logic [31:0] next_random(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] status_of(input int count, input logic ovf);
        logic [31:0] w;
        w = '0;
        w[STAT_COUNT_LSB +: 4] = 4'(count);
        w[STAT_OVERFLOW]       = ovf;
        w[STAT_NOT_EMPTY]      = (count != 0);
        return w;
    endfunction

    function automatic logic [31:0] data_of(input int idx);
        logic [31:0] w;
        w                 = '0;
        w[3:0]            = 4'(idx);
        w[DATA_VALID_BIT] = 1'b1;
        return w;
    endfunction

    function automatic int run_limit();
        int total;
        total = AXI_OVERHEAD + (6 + 60 + 6) * SCAN_CYCLES;    // Presses outside the table.
        foreach (t_hold[i]) begin
            total = total + (t_hold[i] + 3) * SCAN_CYCLES;
        end
        return 2 * total;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped on error.");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s = 0x%0h, expected 0x%0h",
                                $time, name, got, exp));
        end
    endtask

    // ==============================
    // AXI4-Lite master
    // ==============================
    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(posedge clk);
        #1;
        s_awaddr  = addr;
        s_wdata   = data;
        s_wstrb   = 4'hF;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        s_bready  = 1'b1;
        @(posedge clk);
        while (!s_awready) @(posedge clk);
        #1;
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        @(posedge clk);
        while (!s_bvalid) @(posedge clk);
        resp = s_bresp;
        #1;
        s_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(posedge clk);
        #1;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        s_rready  = 1'b1;
        @(posedge clk);
        while (!s_arready) @(posedge clk);
        #1;
        s_arvalid = 1'b0;
        @(posedge clk);
        while (!s_rvalid) @(posedge clk);
        data = s_rdata;
        resp = s_rresp;
        #1;
        s_rready = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        check("bresp", 32'(resp), 32'(RESP_OKAY));
    endtask

    task automatic expect_reg(input logic [3:0] addr, input logic [31:0] exp,
                              input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, data, resp);
        check("rresp", 32'(resp), 32'(RESP_OKAY));
        check(name, data, exp);
    endtask

    // ==============================
    // Keypad stimulus
    // ==============================
    task automatic press_keys(input logic [15:0] keys, input int hold);
        @(posedge clk);
        #1;
        kp_keys   = keys;
        kp_hold   = hold;
        kp_active = 1'b1;
        @(posedge clk);
        while (!kp_done) @(posedge clk);
        #1;
        kp_active = 1'b0;
    endtask

    task automatic add_entry(input logic [15:0] keys, input int hold, input int exp);
        t_keys.push_back(keys);
        t_hold.push_back(hold);
        t_exp.push_back(exp);
    endtask

    task automatic run_entry(input int i);
        press_keys(t_keys[i], t_hold[i]);
        if (t_exp[i] >= 0) begin
            expect_reg(REG_STATUS, status_of(1, 1'b0), "STATUS");
            expect_reg(REG_DATA, data_of(t_exp[i]), "DATA");
        end
        expect_reg(REG_STATUS, status_of(0, 1'b0), "STATUS");    // Nothing extra queued.
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        int          perm [16];
        int          j;
        int          tmp;

        rst_n     = 1'b0;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        kp_keys   = '0;
        kp_hold   = 0;
        kp_active = 1'b0;

        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                add_entry(16'(1) << (r * 4 + c), 3, r * 4 + c);
            end
        end
        add_entry(16'(1) << 5, 1, -1);                         // Too short.
        add_entry((16'(1) << 2) | (16'(1) << 10), 3, -1);      // Two rows, one column.
        add_entry(16'(1) << 12, 6, 12);                        // Long hold, one event.
        limit = run_limit();

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset state.
        expect_reg(REG_CTRL, 32'h0, "CTRL");
        expect_reg(REG_STATUS, 32'h0, "STATUS");
        check("irq", 32'(irq), 32'h0);
        check("col_out", 32'(col_out), 32'hF);

        write_reg(REG_CTRL, 32'h1);
        for (int i = 0; i < t_keys.size(); i++) begin
            run_entry(i);
        end

        // Interrupt follows the FIFO level.
        write_reg(REG_CTRL, 32'h3);
        check("irq", 32'(irq), 32'h0);
        press_keys(16'(1) << 6, 3);
        check("irq", 32'(irq), 32'h1);
        expect_reg(REG_DATA, data_of(1 * 4 + 2), "DATA");
        @(posedge clk);
        #1;
        check("irq", 32'(irq), 32'h0);
        expect_reg(REG_DATA, 32'h0, "DATA");
        write_reg(REG_CTRL, 32'h1);

        // Overflow with ten keys in random order.
        for (int i = 0; i < 16; i++) begin
            perm[i] = i;
        end
        for (int i = 15; i > 0; i--) begin
            rng     = next_random(rng);
            j       = int'(rng % 32'(i + 1));
            tmp     = perm[i];
            perm[i] = perm[j];
            perm[j] = tmp;
        end
        for (int k = 0; k < 10; k++) begin
            press_keys(16'(1) << perm[k], 3);
        end
        expect_reg(REG_STATUS, status_of(FIFO_DEPTH, 1'b1), "STATUS");
        for (int k = 0; k < FIFO_DEPTH; k++) begin
            expect_reg(REG_DATA, data_of(perm[k]), "DATA");
        end
        expect_reg(REG_STATUS, status_of(0, 1'b1), "STATUS");
        write_reg(REG_STATUS, 32'h2);
        expect_reg(REG_STATUS, 32'h0, "STATUS");

        // Unmapped address, then scanning off.
        axi_read(4'hC, data, resp);
        check("rresp", 32'(resp), 32'(RESP_SLVERR));
        axi_write(4'hC, 32'h3, resp);
        check("bresp", 32'(resp), 32'(RESP_SLVERR));
        expect_reg(REG_CTRL, 32'h1, "CTRL");
        write_reg(REG_CTRL, 32'h0);
        @(posedge clk);
        #1;
        kp_keys   = 16'(1) << 9;
        kp_hold   = 3;
        kp_active = 1'b1;
        repeat (3 * SCAN_CYCLES) begin
            @(posedge clk);
            #1;
            check("col_out", 32'(col_out), 32'hF);
        end
        #1;
        kp_active = 1'b0;
        expect_reg(REG_STATUS, 32'h0, "STATUS");

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: filelist.f
hdl/keypad_pkg.sv
hdl/axi_lite_if.sv
hdl/keypad_scanner.sv
hdl/key_event_fifo.sv
hdl/keypad_axil_regs.sv
hdl/keypad_ctrl_top.sv
bench/keypad_model.sv
bench/tb_keypad_ctrl.sv

// File: hdl/axi_lite_if.sv
`timescale 1ns/1ps

interface axi_lite_if
    import keypad_pkg::*;
();

    logic [AXI_ADDR_W-1:0]   awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [AXI_DATA_W-1:0]   wdata;
    logic [AXI_DATA_W/8-1:0] wstrb;
    logic                    wvalid;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready;
    logic [AXI_ADDR_W-1:0]   araddr;
    logic                    arvalid;
    logic                    arready;
    logic [AXI_DATA_W-1:0]   rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
    logic                    rready;

    modport slave (
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

    modport master (
        output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

endinterface

// File: hdl/key_event_fifo.sv
`timescale 1ns/1ps

module key_event_fifo
    import keypad_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        push,
    input  key_index_t                  wr_data,
    input  logic                        pop,
    output key_index_t                  rd_data,
    output logic                        empty,
    output logic [$clog2(FIFO_DEPTH):0] count,
    output logic                        overflow
);

    localparam int AW = $clog2(FIFO_DEPTH);

    key_index_t    mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign full    = (count == (AW+1)'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;     // Dropped when full.
    assign do_pop  = pop && !empty;
    assign rd_data = mem[rd_ptr];       // Head is visible without latency.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= push && full;   // One-cycle pulse.
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither.
            endcase
        end
    end

endmodule

// File: hdl/keypad_axil_regs.sv
`timescale 1ns/1ps

module keypad_axil_regs
    import keypad_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    axi_lite_if.slave                   bus,
    input  key_index_t                  fifo_rd_data,
    input  logic                        fifo_empty,
    input  logic [$clog2(FIFO_DEPTH):0] fifo_count,
    input  logic                        fifo_overflow,
    output logic                        fifo_pop,
    output logic                        scan_en,
    output logic                        irq
);

    localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

    logic [1:0]            ctrl;
    logic                  ovf_sticky;

    logic                  wr_fire;
    logic                  rd_fire;
    logic                  wr_hit;
    logic                  rd_hit;
    logic                  ovf_clr;
    logic [AXI_DATA_W-1:0] status_word;
    logic [AXI_DATA_W-1:0] data_word;
    logic [AXI_DATA_W-1:0] rd_word;

    // ==============================
    // Address decode
    // ==============================
    assign wr_fire = bus.awvalid && bus.awready && bus.wvalid && bus.wready;
    assign rd_fire = bus.arvalid && bus.arready;

    assign wr_hit = (bus.awaddr == REG_CTRL) || (bus.awaddr == REG_STATUS) ||
                    (bus.awaddr == REG_DATA);
    assign rd_hit = (bus.araddr == REG_CTRL) || (bus.araddr == REG_STATUS) ||
                    (bus.araddr == REG_DATA);

    assign ovf_clr = wr_fire && (bus.awaddr == REG_STATUS) && bus.wstrb[0] &&
                     bus.wdata[STAT_OVERFLOW];

    // Pop in the same cycle the DATA read is accepted.
    assign fifo_pop = rd_fire && (bus.araddr == REG_DATA) && !fifo_empty;

    always_comb begin
        status_word                                = '0;
        status_word[STAT_NOT_EMPTY]                = !fifo_empty;
        status_word[STAT_OVERFLOW]                 = ovf_sticky;
        status_word[STAT_COUNT_LSB +: CNT_W]       = fifo_count;
    end

    always_comb begin
        data_word = '0;
        if (!fifo_empty) begin
            data_word[$bits(key_index_t)-1:0] = fifo_rd_data;
            data_word[DATA_VALID_BIT]         = 1'b1;
        end
    end

    always_comb begin
        case (bus.araddr)
            REG_CTRL:   rd_word = {{(AXI_DATA_W-2){1'b0}}, ctrl};
            REG_STATUS: rd_word = status_word;
            REG_DATA:   rd_word = data_word;
            default:    rd_word = '0;
        endcase
    end

    // ==============================
    // Write channel
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.awready <= 1'b0;
            bus.wready  <= 1'b0;
            bus.bvalid  <= 1'b0;
            bus.bresp   <= RESP_OKAY;
            ctrl        <= '0;
        end else begin
            if (wr_fire) begin
                bus.awready <= 1'b0;
                bus.wready  <= 1'b0;
                bus.bvalid  <= 1'b1;
                bus.bresp   <= wr_hit ? RESP_OKAY : RESP_SLVERR;
                if (bus.awaddr == REG_CTRL && bus.wstrb[0]) begin
                    ctrl <= bus.wdata[1:0];
                end
            end else if (bus.awvalid && bus.wvalid && !bus.awready && !bus.bvalid) begin
                bus.awready <= 1'b1;    // Both accepted together.
                bus.wready  <= 1'b1;
            end
            if (bus.bvalid && bus.bready) begin
                bus.bvalid <= 1'b0;
            end
        end
    end

    // ==============================
    // Read channel
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.arready <= 1'b0;
            bus.rvalid  <= 1'b0;
            bus.rresp   <= RESP_OKAY;
        end else begin
            if (rd_fire) begin
                bus.arready <= 1'b0;
                bus.rvalid  <= 1'b1;
                bus.rresp   <= rd_hit ? RESP_OKAY : RESP_SLVERR;
            end else if (bus.arvalid && !bus.arready && !bus.rvalid) begin
                bus.arready <= 1'b1;
            end
            if (bus.rvalid && bus.rready) begin
                bus.rvalid <= 1'b0;
            end
        end
    end

    // Read data is a payload register.
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            bus.rdata <= rd_word;
        end
    end

    // ==============================
    // Overflow and interrupt
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ovf_sticky <= 1'b0;
            irq        <= 1'b0;
        end else begin
            if (fifo_overflow) begin
                ovf_sticky <= 1'b1;     // Set beats a clear in the same cycle.
            end else if (ovf_clr) begin
                ovf_sticky <= 1'b0;
            end
            irq <= ctrl[CTRL_IRQ_EN] && !fifo_empty;
        end
    end

    assign scan_en = ctrl[CTRL_SCAN_EN];

endmodule

// File: hdl/keypad_ctrl_top.sv
`timescale 1ns/1ps

module keypad_ctrl_top
    import keypad_pkg::*;
#(
    parameter int COLUMN_CYCLES = 16,
    parameter int SETTLE_CYCLES = 4,
    parameter int FIFO_DEPTH    = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [ROWS-1:0]         row_in,
    output logic [COLS-1:0]         col_out,
    input  logic [AXI_ADDR_W-1:0]   s_awaddr,
    input  logic                    s_awvalid,
    output logic                    s_awready,
    input  logic [AXI_DATA_W-1:0]   s_wdata,
    input  logic [AXI_DATA_W/8-1:0] s_wstrb,
    input  logic                    s_wvalid,
    output logic                    s_wready,
    output logic [1:0]              s_bresp,
    output logic                    s_bvalid,
    input  logic                    s_bready,
    input  logic [AXI_ADDR_W-1:0]   s_araddr,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output logic [AXI_DATA_W-1:0]   s_rdata,
    output logic [1:0]              s_rresp,
    output logic                    s_rvalid,
    input  logic                    s_rready,
    output logic                    irq
);

    logic                        scan_en;
    logic                        key_valid;
    key_index_t                  key_index;
    key_index_t                  fifo_rd_data;
    logic                        fifo_empty;
    logic [$clog2(FIFO_DEPTH):0] fifo_count;
    logic                        fifo_overflow;
    logic                        fifo_pop;

    axi_lite_if bus ();

    // Plain ports onto the bus interface.
    assign bus.awaddr  = s_awaddr;
    assign bus.awvalid = s_awvalid;
    assign bus.wdata   = s_wdata;
    assign bus.wstrb   = s_wstrb;
    assign bus.wvalid  = s_wvalid;
    assign bus.bready  = s_bready;
    assign bus.araddr  = s_araddr;
    assign bus.arvalid = s_arvalid;
    assign bus.rready  = s_rready;
    assign s_awready   = bus.awready;
    assign s_wready    = bus.wready;
    assign s_bresp     = bus.bresp;
    assign s_bvalid    = bus.bvalid;
    assign s_arready   = bus.arready;
    assign s_rdata     = bus.rdata;
    assign s_rresp     = bus.rresp;
    assign s_rvalid    = bus.rvalid;

    keypad_scanner #(
        .COLUMN_CYCLES (COLUMN_CYCLES),
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) u_scanner (
        .clk       (clk),
        .rst_n     (rst_n),
        .scan_en   (scan_en),
        .row_in    (row_in),
        .col_out   (col_out),
        .key_valid (key_valid),
        .key_index (key_index)
    );

    key_event_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (key_valid),
        .wr_data  (key_index),
        .pop      (fifo_pop),
        .rd_data  (fifo_rd_data),
        .empty    (fifo_empty),
        .count    (fifo_count),
        .overflow (fifo_overflow)
    );

    keypad_axil_regs #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus           (bus.slave),
        .fifo_rd_data  (fifo_rd_data),
        .fifo_empty    (fifo_empty),
        .fifo_count    (fifo_count),
        .fifo_overflow (fifo_overflow),
        .fifo_pop      (fifo_pop),
        .scan_en       (scan_en),
        .irq           (irq)
    );

endmodule

// File: hdl/keypad_pkg.sv
package keypad_pkg;

    // ==============================
    // Keypad matrix
    // ==============================
    localparam int ROWS = 4;
    localparam int COLS = 4;

    typedef logic [3:0] key_index_t;    // Row * 4 + column.

    // ==============================
    // AXI4-Lite bus
    // ==============================
    localparam int AXI_ADDR_W = 4;
    localparam int AXI_DATA_W = 32;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Register offsets.
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL   = 4'h0;
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 4'h4;
    localparam logic [AXI_ADDR_W-1:0] REG_DATA   = 4'h8;

    // CTRL bits.
    localparam int CTRL_SCAN_EN = 0;
    localparam int CTRL_IRQ_EN  = 1;

    // STATUS bits.
    localparam int STAT_NOT_EMPTY = 0;
    localparam int STAT_OVERFLOW  = 1;    // Sticky, write 1 to clear.
    localparam int STAT_COUNT_LSB = 4;    // Count sits in bits 7:4.

    // DATA bits.
    localparam int DATA_VALID_BIT = 8;

endpackage

// File: hdl/keypad_scanner.sv
`timescale 1ns/1ps

module keypad_scanner
    import keypad_pkg::*;
#(
    parameter int COLUMN_CYCLES = 16,
    parameter int SETTLE_CYCLES = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            scan_en,
    input  logic [ROWS-1:0] row_in,
    output logic [COLS-1:0] col_out,    // Active low.
    output logic            key_valid,
    output key_index_t      key_index
);

    localparam int CNT_W = $clog2(COLUMN_CYCLES);
    localparam int COL_W = $clog2(COLS);
    localparam int ROW_W = $clog2(ROWS);

    logic [CNT_W-1:0] cnt;
    logic [COL_W-1:0] col_ptr;
    logic             scan_on;      // Column 0 has been started.
    logic [ROWS-1:0]  row_prev [COLS];
    logic [ROWS-1:0]  row_old  [COLS];

    logic             last_cycle;
    logic             sample_pt;
    logic             single_low;
    logic             press_hit;
    logic [ROW_W-1:0] row_idx;
    logic [COL_W-1:0] next_ptr;

    // Index of the single low row line.
    function automatic logic [ROW_W-1:0] low_row(input logic [ROWS-1:0] rows);
        logic [ROW_W-1:0] idx;
        idx = '0;
        for (int r = 0; r < ROWS; r++) begin
            if (!rows[r]) begin
                idx = ROW_W'(r);
            end
        end
        return idx;
    endfunction

    // ==============================
    // Press qualification
    // ==============================
    assign last_cycle = (cnt == CNT_W'(COLUMN_CYCLES - 1));
    assign sample_pt  = scan_on && (cnt == CNT_W'(SETTLE_CYCLES));
    assign single_low = ($countones(~row_in) == 1);
    assign row_idx    = low_row(row_in);
    assign next_ptr   = col_ptr + 1'b1;

    assign press_hit = single_low &&
                       (row_prev[col_ptr] == row_in) &&    // Same pattern last scan.
                       (row_old[col_ptr] == '1);           // Nothing pressed before that.

    // ==============================
    // Column stepping
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n || !scan_en) begin
            cnt     <= '0;
            col_ptr <= '0;
            scan_on <= 1'b0;
            col_out <= '1;              // All columns idle.
        end else if (!scan_on) begin
            scan_on <= 1'b1;
            col_out <= ~(COLS'(1));     // Restart at column 0.
        end else if (last_cycle) begin
            cnt     <= '0;
            col_ptr <= next_ptr;
            col_out <= ~(COLS'(1) << next_ptr);
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // ==============================
    // Scan history and event
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n || !scan_en) begin
            key_valid <= 1'b0;
            for (int c = 0; c < COLS; c++) begin
                row_prev[c] <= '1;
                row_old[c]  <= '1;
            end
        end else begin
            key_valid <= sample_pt && press_hit;
            if (sample_pt) begin
                row_old[col_ptr]  <= row_prev[col_ptr];
                row_prev[col_ptr] <= row_in;
            end
        end
    end

    // Payload only, qualified by key_valid.
    always_ff @(posedge clk) begin
        if (sample_pt) begin
            key_index <= {row_idx, col_ptr};
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the keypad controller testbench with Verilator.

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --top-module tb_keypad_ctrl -f filelist.f -o tb_keypad_ctrl \
    > build.log 2>&1 \
    && { ./obj_dir/tb_keypad_ctrl > sim.log 2>&1 || true; } \
    || { echo "Verilator build failed, see build.log"; exit 1; }

[ -s sim.log ] || { echo "Simulation produced no output"; exit 1; }

grep -q "SOME TESTS FAILED" sim.log \
    && { echo "Simulation failed, see sim.log"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
